/* common/abr_params_pkg.sv */
//==============================
// Memory interface types
//==============================

`include "compress_consts.svh"

package abr_params_pkg;

    // Access type of a memory request
    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } mem_rw_t;

    // One request on a memory port, an idle request carries no access
    typedef struct packed {
        mem_rw_t                        rd_wr_en;
        logic [`ABR_MEM_ADDR_WIDTH-1:0] addr;
    } mem_if_t;

endpackage

/* common/compress_consts.svh */
//==============================
// ML-KEM compression constants
//==============================

`ifndef COMPRESS_CONSTS_SVH
`define COMPRESS_CONSTS_SVH

// Field modulus and coefficient width
`define MLKEM_Q 3329
`define MLKEM_Q_WIDTH 12

// Datapath throughput, four coefficients per memory word
`define COEFF_PER_CLK 4

// Coefficients in one polynomial
`define COEFFS_PER_POLY 256

// Each coefficient occupies one slot of this width in a memory word,
// with the value in the low MLKEM_Q_WIDTH bits
`define REG_SIZE 24

// Width of an API memory word
`define DATA_WIDTH 32

// Address width shared by the coefficient memory and the API memory
`define ABR_MEM_ADDR_WIDTH 15

`endif

/* common/compress_defines_pkg.sv */
//==============================
// Compression types
//==============================

package compress_defines_pkg;

    // Output width d of the compression, 1, 5, 11 or 12 bits
    typedef enum logic [1:0] {
        compress1  = 2'd0,
        compress5  = 2'd1,
        compress11 = 2'd2,
        compress12 = 2'd3
    } compress_mode_t;

    // States of the coefficient read controller
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,
        CTRL_READ  = 2'd1,
        CTRL_STALL = 2'd2,
        CTRL_DONE  = 2'd3
    } compress_ctrl_state_t;

endpackage

/* compress.f */
+incdir+common
common/abr_params_pkg.sv
common/compress_defines_pkg.sv
compress/compress_unit.sv
compress/compress_sample_buffer.sv
compress/compress_ctrl.sv
compress/compress_top.sv
verif/compress_tb.sv

/* compress/compress_ctrl.sv */
//==============================
// Compression read controller
//==============================

`timescale 1ns/1ps
`include "compress_consts.svh"

module compress_ctrl (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  logic                           enable_i,
    input  logic [2:0]                     num_poly_i,
    input  logic [`ABR_MEM_ADDR_WIDTH-1:0] src_base_addr_i,
    input  logic                           buffer_full_i,
    output abr_params_pkg::mem_if_t        mem_rd_req_o,
    output logic                           rd_valid_o,
    output logic                           rd_hold_o,
    output logic                           done_o
);

    localparam int READS_PER_POLY = `COEFFS_PER_POLY / `COEFF_PER_CLK;
    localparam int RD_CNT_W = $clog2(READS_PER_POLY);

    compress_defines_pkg::compress_ctrl_state_t state_q, state_nxt;
    logic [RD_CNT_W-1:0]            rd_cnt_q;
    logic [2:0]                     poly_cnt_q;
    logic [`ABR_MEM_ADDR_WIDTH-1:0] rd_addr_q;
    logic                           rd_fire;
    logic                           last_in_poly;
    logic                           last_rd;

    // A read goes out only while the sample buffer can take the returning word
    assign rd_fire = (state_q == compress_defines_pkg::CTRL_READ) && !buffer_full_i;
    assign last_in_poly = rd_cnt_q == RD_CNT_W'(READS_PER_POLY - 1);
    assign last_rd = last_in_poly && (poly_cnt_q == num_poly_i - 3'd1);

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            compress_defines_pkg::CTRL_READ: begin
                if (buffer_full_i) begin
                    state_nxt = compress_defines_pkg::CTRL_STALL;
                end else if (last_rd) begin
                    state_nxt = compress_defines_pkg::CTRL_DONE;
                end
            end
            compress_defines_pkg::CTRL_STALL: begin
                if (!buffer_full_i) begin
                    state_nxt = compress_defines_pkg::CTRL_READ;
                end
            end
            default: begin
                // Idle and done both wait for the next command
                if (enable_i) begin
                    state_nxt = compress_defines_pkg::CTRL_READ;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= compress_defines_pkg::CTRL_IDLE;
            rd_cnt_q   <= '0;
            poly_cnt_q <= '0;
            rd_addr_q  <= '0;
            rd_valid_o <= 1'b0;
        end else if (zeroize_i) begin
            state_q    <= compress_defines_pkg::CTRL_IDLE;
            rd_cnt_q   <= '0;
            poly_cnt_q <= '0;
            rd_addr_q  <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            state_q    <= state_nxt;
            rd_valid_o <= rd_fire;
            if (enable_i) begin
                rd_cnt_q   <= '0;
                poly_cnt_q <= '0;
                rd_addr_q  <= src_base_addr_i;
            end else if (rd_fire) begin
                // The read counter wraps to zero at each polynomial boundary
                rd_cnt_q  <= rd_cnt_q + 1'b1;
                rd_addr_q <= rd_addr_q + 1'b1;
                if (last_in_poly) begin
                    poly_cnt_q <= poly_cnt_q + 3'd1;
                end
            end
        end
    end

    always_comb begin
        mem_rd_req_o.rd_wr_en = rd_fire ? abr_params_pkg::RW_READ : abr_params_pkg::RW_IDLE;
        mem_rd_req_o.addr     = rd_fire ? rd_addr_q : '0;
    end

    // Data returning now is refused by the buffer and must be replayed next cycle
    assign rd_hold_o = rd_valid_o && buffer_full_i;
    assign done_o = state_q == compress_defines_pkg::CTRL_DONE;

endmodule

/* compress/compress_sample_buffer.sv */
//==============================
// Nibble packing buffer
//==============================

`timescale 1ns/1ps

module compress_sample_buffer #(
    parameter int BUFFER_DATA_W = 4,
    parameter int NUM_WR = 12,
    parameter int NUM_RD = 8
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize_i,
    input  logic [NUM_WR*BUFFER_DATA_W-1:0] data_i,
    input  logic [NUM_WR-1:0]               data_valid_i,
    output logic                            buffer_full_o,
    output logic                            data_valid_o,
    output logic [NUM_RD*BUFFER_DATA_W-1:0] data_o
);

    localparam int DEPTH = 2 * NUM_WR;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DEPTH-1:0][BUFFER_DATA_W-1:0] store_q;
    logic [DEPTH-1:0][BUFFER_DATA_W-1:0] store_nxt;
    logic [CNT_W-1:0]                    count_q;
    logic [CNT_W-1:0]                    count_left;
    logic [CNT_W-1:0]                    wr_cnt;
    logic                                accept;

    // The oldest NUM_RD entries form the output word whenever they are all present
    assign data_valid_o = count_q >= CNT_W'(NUM_RD);
    assign data_o = store_q[NUM_RD-1:0];

    // Fill level after this cycle's pop, a full write must still fit on top of it
    assign count_left = data_valid_o ? count_q - CNT_W'(NUM_RD) : count_q;
    assign buffer_full_o = count_left > CNT_W'(DEPTH - NUM_WR);
    assign accept = !buffer_full_o;

    // Valid bits are contiguous from bit 0, so their count is the write length
    always_comb begin
        wr_cnt = '0;
        for (int i = 0; i < NUM_WR; i++) begin
            wr_cnt = wr_cnt + CNT_W'(data_valid_i[i]);
        end
    end

    always_comb begin
        store_nxt = data_valid_o ? store_q >> (NUM_RD * BUFFER_DATA_W) : store_q;
        for (int i = 0; i < NUM_WR; i++) begin
            if (accept && data_valid_i[i]) begin
                store_nxt[int'(count_left) + i] = data_i[i*BUFFER_DATA_W +: BUFFER_DATA_W];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count_q <= '0;
        end else if (zeroize_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_left + (accept ? wr_cnt : '0);
        end
    end

    // Zeroize wipes the stored samples along with the fill level
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            store_q <= '0;
        end else begin
            store_q <= store_nxt;
        end
    end

endmodule

/* compress/compress_top.sv */
//==============================
// Polynomial compression top
//==============================

`timescale 1ns/1ps
`include "compress_consts.svh"

module compress_top (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      zeroize_i,
    input  logic                                      compress_enable_i,
    input  compress_defines_pkg::compress_mode_t      mode_i,
    input  logic                                      compare_mode_i,
    input  logic [2:0]                                num_poly_i,
    input  logic [`ABR_MEM_ADDR_WIDTH-1:0]            src_base_addr_i,
    input  logic [`ABR_MEM_ADDR_WIDTH-1:0]            dest_base_addr_i,
    output abr_params_pkg::mem_if_t                   mem_rd_req_o,
    input  logic [`COEFF_PER_CLK-1:0][`REG_SIZE-1:0]  mem_rd_data_i,
    output logic [1:0]                                api_rw_en_o,
    output logic [`ABR_MEM_ADDR_WIDTH-1:0]            api_rw_addr_o,
    output logic [`DATA_WIDTH-1:0]                    api_wr_data_o,
    input  logic [`DATA_WIDTH-1:0]                    api_rd_data_i,
    output logic                                      compare_failed_o,
    output logic                                      compress_done_o
);

    localparam int NIB_W = 4;
    localparam int NUM_NIB = `COEFF_PER_CLK * `MLKEM_Q_WIDTH / NIB_W;

    logic [`COEFF_PER_CLK-1:0][`MLKEM_Q_WIDTH-1:0] lane_in, lane_out, stalled_q;
    logic [NUM_NIB*NIB_W-1:0] nib_data;
    logic [NUM_NIB-1:0]       nib_mask;
    logic [NUM_NIB-1:0]       nib_valid;
    logic                     rd_valid, rd_hold, hold_q;
    logic                     read_done, buffer_full;
    logic                     buffer_valid, buffer_valid_q;
    logic [`DATA_WIDTH-1:0]   buffer_data, buffer_data_q;
    logic                     busy_q;

    compress_ctrl u_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .enable_i        (compress_enable_i),
        .num_poly_i      (num_poly_i),
        .src_base_addr_i (src_base_addr_i),
        .buffer_full_i   (buffer_full),
        .mem_rd_req_o    (mem_rd_req_o),
        .rd_valid_o      (rd_valid),
        .rd_hold_o       (rd_hold),
        .done_o          (read_done)
    );

    // In the cycle after a refused word, the lanes see the staged copy instead of memory
    for (genvar i = 0; i < `COEFF_PER_CLK; i++) begin : g_lane
        assign lane_in[i] = hold_q ? stalled_q[i] : mem_rd_data_i[i][`MLKEM_Q_WIDTH-1:0];

        compress_unit u_unit (
            .op_i   (lane_in[i]),
            .mode_i (mode_i),
            .op_o   (lane_out[i])
        );
    end

    // Pack the d low bits of each lane back to back, lane 0 in the low nibbles
    always_comb begin
        nib_data = '0;
        case (mode_i)
            compress_defines_pkg::compress1: begin
                nib_data[3:0] = {lane_out[3][0], lane_out[2][0], lane_out[1][0], lane_out[0][0]};
                nib_mask = 12'h001;
            end
            compress_defines_pkg::compress5: begin
                nib_data[19:0] = {lane_out[3][4:0], lane_out[2][4:0],
                                  lane_out[1][4:0], lane_out[0][4:0]};
                nib_mask = 12'h01F;
            end
            compress_defines_pkg::compress11: begin
                nib_data[43:0] = {lane_out[3][10:0], lane_out[2][10:0],
                                  lane_out[1][10:0], lane_out[0][10:0]};
                nib_mask = 12'h7FF;
            end
            default: begin
                nib_data = lane_out;
                nib_mask = 12'hFFF;
            end
        endcase
    end

    assign nib_valid = (rd_valid || hold_q) ? nib_mask : '0;

    compress_sample_buffer #(
        .BUFFER_DATA_W (NIB_W),
        .NUM_WR        (NUM_NIB),
        .NUM_RD        (`DATA_WIDTH / NIB_W)
    ) u_buffer (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .data_i        (nib_data),
        .data_valid_i  (nib_valid),
        .buffer_full_o (buffer_full),
        .data_valid_o  (buffer_valid),
        .data_o        (buffer_data)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q         <= 1'b0;
            hold_q         <= 1'b0;
            buffer_valid_q <= 1'b0;
            api_rw_addr_o  <= '0;
        end else if (zeroize_i) begin
            busy_q         <= 1'b0;
            hold_q         <= 1'b0;
            buffer_valid_q <= 1'b0;
            api_rw_addr_o  <= '0;
        end else begin
            busy_q         <= compress_enable_i || (busy_q && !compress_done_o);
            hold_q         <= rd_hold;
            buffer_valid_q <= buffer_valid;
            if (compress_enable_i) begin
                api_rw_addr_o <= dest_base_addr_i;
            end else if (|api_rw_en_o) begin
                api_rw_addr_o <= api_rw_addr_o + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            stalled_q     <= '0;
            buffer_data_q <= '0;
        end else begin
            if (rd_hold) begin
                stalled_q <= lane_in;
            end
            if (buffer_valid) begin
                buffer_data_q <= buffer_data;
            end
        end
    end

    // Each command leaves a multiple of 8 nibbles, so a quiet buffer is an empty one
    assign compress_done_o = busy_q && read_done && !rd_valid && !hold_q
                             && !buffer_valid && !buffer_valid_q;

    assign api_rw_en_o = {buffer_valid && compare_mode_i, buffer_valid && !compare_mode_i};
    assign api_wr_data_o = buffer_data;

    // The read data returns one cycle after the access, next to the registered word
    assign compare_failed_o = compare_mode_i && buffer_valid_q && (buffer_data_q != api_rd_data_i);

endmodule

/* compress/compress_unit.sv */
//==============================
// Compression lane
//==============================

`timescale 1ns/1ps
`include "compress_consts.svh"

module compress_unit (
    input  logic [`MLKEM_Q_WIDTH-1:0]        op_i,
    input  compress_defines_pkg::compress_mode_t mode_i,
    output logic [`MLKEM_Q_WIDTH-1:0]        op_o
);

    // ceil(2^35 / q), exact for every numerator below 2^23
    localparam int RECIP_SHIFT = 35;
    localparam logic [23:0] RECIP = 24'd10321340;
    localparam logic [23:0] HALF_Q = 24'(`MLKEM_Q / 2);

    logic [3:0]                d_shift;
    logic [23:0]               scaled;
    logic [47:0]               product;
    logic [`MLKEM_Q_WIDTH-1:0] quot;

    always_comb begin
        case (mode_i)
            compress_defines_pkg::compress1:  d_shift = 4'd1;
            compress_defines_pkg::compress5:  d_shift = 4'd5;
            compress_defines_pkg::compress11: d_shift = 4'd11;
            default:                          d_shift = 4'd0;
        endcase
    end

    // Adding floor(q/2) before the divide rounds to nearest, q is odd so no ties
    assign scaled = (24'(op_i) << d_shift) + HALF_Q;
    assign product = 48'(scaled) * 48'(RECIP);
    assign quot = product[RECIP_SHIFT +: `MLKEM_Q_WIDTH];

    // Keeping only the low d bits performs the mod 2^d
    always_comb begin
        case (mode_i)
            compress_defines_pkg::compress1:  op_o = {11'b0, quot[0]};
            compress_defines_pkg::compress5:  op_o = {7'b0, quot[4:0]};
            compress_defines_pkg::compress11: op_o = {1'b0, quot[10:0]};
            default:                          op_o = op_i;
        endcase
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the compression block and its testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module compress_tb -f compress.f \
    -o compress_sim > build.log 2>&1 \
    || { cat build.log; echo "RESULT: build error"; exit 1; }
./obj_dir/compress_sim > sim.log 2>&1
cat sim.log
grep -qx "Simulation passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }

/* verif/compress_tb.sv */
//==============================
// Compression testbench
//==============================

`timescale 1ns/1ps
`include "compress_consts.svh"

module compress_tb;

    localparam int Q = `MLKEM_Q;
    localparam int READS_PER_POLY = `COEFFS_PER_POLY / `COEFF_PER_CLK;
    // Polynomial counts of every command below, the zeroized one included
    localparam int TOTAL_READS = READS_PER_POLY * (1 + 2 + 2 + 3 + 1 + 1 + 2 + 1);
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_READS + 2000;
    localparam logic [`ABR_MEM_ADDR_WIDTH-1:0] SRC_A = 15'h0040;
    localparam logic [`ABR_MEM_ADDR_WIDTH-1:0] SRC_B = 15'h0100;
    localparam logic [`ABR_MEM_ADDR_WIDTH-1:0] SRC_C = 15'h0200;
    localparam logic [`ABR_MEM_ADDR_WIDTH-1:0] DEST_A = 15'h1000;

    logic                                     clk;
    logic                                     reset_n;
    logic                                     zeroize_i;
    logic                                     compress_enable_i;
    compress_defines_pkg::compress_mode_t     mode_i;
    logic                                     compare_mode_i;
    logic [2:0]                               num_poly_i;
    logic [`ABR_MEM_ADDR_WIDTH-1:0]           src_base_addr_i;
    logic [`ABR_MEM_ADDR_WIDTH-1:0]           dest_base_addr_i;
    abr_params_pkg::mem_if_t                  mem_rd_req_o;
    logic [`COEFF_PER_CLK-1:0][`REG_SIZE-1:0] mem_rd_data_i = '0;
    logic [1:0]                               api_rw_en_o;
    logic [`ABR_MEM_ADDR_WIDTH-1:0]           api_rw_addr_o;
    logic [`DATA_WIDTH-1:0]                   api_wr_data_o;
    logic [`DATA_WIDTH-1:0]                   api_rd_data_i = '0;
    logic                                     compare_failed_o;
    logic                                     compress_done_o;

    // Source coefficients, indexed by {address[9:0], lane}
    logic [`MLKEM_Q_WIDTH-1:0]      coeff_mem [0:4095];
    logic [`DATA_WIDTH-1:0]         api_mem [0:(1 << `ABR_MEM_ADDR_WIDTH)-1];
    logic [`ABR_MEM_ADDR_WIDTH-1:0] flip_addr;
    logic [`DATA_WIDTH-1:0]         flip_mask;
    logic [`DATA_WIDTH-1:0]         exp_q[$];
    logic [`DATA_WIDTH-1:0]         wr_log[$];
    string                          test_name;
    int                             cycle_cnt = 0;
    int                             rd_idx;
    int                             acc_idx;
    int                             gap_cnt;
    int                             api_rd_cnt;
    int                             done_cnt;
    int                             fail_cnt;

    compress_top DUT (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize_i         (zeroize_i),
        .compress_enable_i (compress_enable_i),
        .mode_i            (mode_i),
        .compare_mode_i    (compare_mode_i),
        .num_poly_i        (num_poly_i),
        .src_base_addr_i   (src_base_addr_i),
        .dest_base_addr_i  (dest_base_addr_i),
        .mem_rd_req_o      (mem_rd_req_o),
        .mem_rd_data_i     (mem_rd_data_i),
        .api_rw_en_o       (api_rw_en_o),
        .api_rw_addr_o     (api_rw_addr_o),
        .api_wr_data_o     (api_wr_data_o),
        .api_rd_data_i     (api_rd_data_i),
        .compare_failed_o  (compare_failed_o),
        .compress_done_o   (compress_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // round(2^d * x / q) mod 2^d written as floor((2 * 2^d * x + q) / 2q)
    function automatic int compress_ref(input int x, input int d);
        if (d == 12) begin
            return x;
        end
        return ((2 * x * (1 << d) + Q) / (2 * Q)) % (1 << d);
    endfunction

    // The upper half of each slot carries junk that the DUT must ignore
    function automatic logic [`COEFF_PER_CLK*`REG_SIZE-1:0] src_word(input int addr);
        logic [`COEFF_PER_CLK*`REG_SIZE-1:0] word;
        for (int lane = 0; lane < `COEFF_PER_CLK; lane++) begin
            word[lane*`REG_SIZE +: `REG_SIZE] = {~coeff_mem[(addr % 1024) * 4 + lane],
                                                 coeff_mem[(addr % 1024) * 4 + lane]};
        end
        return word;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s: %s expected %0h actual %0h",
                               test_name, what, expected, actual));
        end
    endtask

    // Memory models and bus monitor, per-command counts restart at each command
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("ERROR: the run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
        end
        if (compress_enable_i) begin
            rd_idx = 0;
            acc_idx = 0;
            gap_cnt = 0;
            api_rd_cnt = 0;
            done_cnt = 0;
            fail_cnt = 0;
            wr_log.delete();
        end
        if (mem_rd_req_o.rd_wr_en == abr_params_pkg::RW_READ) begin
            check_value("source address", 32'(src_base_addr_i) + 32'(rd_idx),
                        32'(mem_rd_req_o.addr));
            mem_rd_data_i <= src_word(int'(mem_rd_req_o.addr));
            rd_idx++;
        end else if (rd_idx > 0 && rd_idx < READS_PER_POLY * int'(num_poly_i)) begin
            gap_cnt++;
        end
        if (api_rw_en_o == 2'b11) begin
            fail_run("ERROR: API read and write enabled in the same cycle");
        end
        if (api_rw_en_o[0]) begin
            api_mem[api_rw_addr_o] <= api_wr_data_o;
            wr_log.push_back(api_wr_data_o);
        end
        if (api_rw_en_o[1]) begin
            api_rd_data_i <= api_mem[api_rw_addr_o]
                             ^ ((api_rw_addr_o == flip_addr) ? flip_mask : 32'h0);
            api_rd_cnt++;
        end
        if (|api_rw_en_o) begin
            check_value("API address", 32'(dest_base_addr_i) + 32'(acc_idx),
                        32'(api_rw_addr_o));
            acc_idx++;
        end
        done_cnt += int'(compress_done_o);
        fail_cnt += int'(compare_failed_o);
    end

    // Little-endian bit packing of the reference compressed coefficients
    task automatic build_expected(input compress_defines_pkg::compress_mode_t mode,
                                  input int src, input int npoly);
        int          d;
        int          nbits;
        logic [63:0] acc;
        case (mode)
            compress_defines_pkg::compress1:  d = 1;
            compress_defines_pkg::compress5:  d = 5;
            compress_defines_pkg::compress11: d = 11;
            default:                          d = 12;
        endcase
        exp_q.delete();
        acc = '0;
        nbits = 0;
        for (int a = 0; a < READS_PER_POLY * npoly; a++) begin
            for (int lane = 0; lane < `COEFF_PER_CLK; lane++) begin
                acc |= 64'(compress_ref(int'(coeff_mem[((src + a) % 1024) * 4 + lane]), d))
                       << nbits;
                nbits += d;
                if (nbits >= 32) begin
                    exp_q.push_back(acc[31:0]);
                    acc >>= 32;
                    nbits -= 32;
                end
            end
        end
    endtask

    task automatic start_command(input string name,
                                 input compress_defines_pkg::compress_mode_t mode,
                                 input logic cmp, input int npoly,
                                 input logic [`ABR_MEM_ADDR_WIDTH-1:0] src,
                                 input logic [`ABR_MEM_ADDR_WIDTH-1:0] dest);
        test_name = name;
        @(posedge clk);
        mode_i <= mode;
        compare_mode_i <= cmp;
        num_poly_i <= 3'(npoly);
        src_base_addr_i <= src;
        dest_base_addr_i <= dest;
        compress_enable_i <= 1'b1;
        @(posedge clk);
        compress_enable_i <= 1'b0;
    endtask

    task automatic run_command(input string name,
                               input compress_defines_pkg::compress_mode_t mode,
                               input logic cmp, input int npoly,
                               input logic [`ABR_MEM_ADDR_WIDTH-1:0] src,
                               input logic [`ABR_MEM_ADDR_WIDTH-1:0] dest,
                               input int exp_fails);
        build_expected(mode, int'(src), npoly);
        start_command(name, mode, cmp, npoly, src, dest);
        do begin
            @(posedge clk);
        end while (compress_done_o !== 1'b1);
        // A few quiet cycles expose a second done pulse or a stray access
        repeat (4) @(posedge clk);
        check_value("done pulses", 32'd1, 32'(done_cnt));
        check_value("source reads", 32'(READS_PER_POLY * npoly), 32'(rd_idx));
        check_value("compare failures", 32'(exp_fails), 32'(fail_cnt));
        if (cmp) begin
            check_value("API writes", 32'd0, 32'(wr_log.size()));
            check_value("API reads", 32'(exp_q.size()), 32'(api_rd_cnt));
        end else begin
            check_value("API writes", 32'(exp_q.size()), 32'(wr_log.size()));
            check_value("API reads", 32'd0, 32'(api_rd_cnt));
            foreach (exp_q[i]) begin
                check_value($sformatf("word %0d", i), exp_q[i], wr_log[i]);
            end
        end
    endtask

    task automatic test_compress12();
        run_command("compress12 one poly", compress_defines_pkg::compress12, 1'b0, 1,
                    SRC_A, DEST_A, 0);
    endtask

    task automatic test_compress1_5();
        run_command("compress1 two polys", compress_defines_pkg::compress1, 1'b0, 2,
                    SRC_B, 15'h2000, 0);
        run_command("compress5 two polys", compress_defines_pkg::compress5, 1'b0, 2,
                    SRC_B, 15'h2400, 0);
    endtask

    task automatic test_compress11_stall();
        run_command("compress11 three polys", compress_defines_pkg::compress11, 1'b0, 3,
                    SRC_B, 15'h3000, 0);
        check_value("idle read cycles seen", 32'd1, 32'(gap_cnt > 0));
    endtask

    task automatic test_compare_match();
        run_command("compare matching", compress_defines_pkg::compress12, 1'b1, 1,
                    SRC_A, DEST_A, 0);
    endtask

    task automatic test_compare_mismatch();
        flip_addr = DEST_A + 15'd37;
        flip_mask = 32'h0000_0100;
        run_command("compare corrupted", compress_defines_pkg::compress12, 1'b1, 1,
                    SRC_A, DEST_A, 1);
        flip_mask = '0;
    endtask

    task automatic test_zeroize();
        start_command("zeroize mid command", compress_defines_pkg::compress12, 1'b0, 2,
                      SRC_C, 15'h4000);
        repeat (50) @(posedge clk);
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        repeat (30) begin
            @(posedge clk);
            check_value("read request", 32'(abr_params_pkg::RW_IDLE),
                        32'(mem_rd_req_o.rd_wr_en));
            check_value("API enables", 32'd0, 32'(api_rw_en_o));
            check_value("done", 32'd0, 32'(compress_done_o));
            check_value("compare failed", 32'd0, 32'(compare_failed_o));
        end
        run_command("command after zeroize", compress_defines_pkg::compress5, 1'b0, 1,
                    SRC_C, 15'h5000, 0);
    endtask

    initial begin
        logic [31:0] seed;
        reset_n <= 1'b0;
        zeroize_i <= 1'b0;
        compress_enable_i <= 1'b0;
        mode_i <= compress_defines_pkg::compress12;
        compare_mode_i <= 1'b0;
        num_poly_i <= 3'd1;
        src_base_addr_i <= '0;
        dest_base_addr_i <= '0;
        flip_addr = '0;
        flip_mask = '0;
        test_name = "reset";
        seed = 32'd9;
        for (int i = 0; i < 4096; i++) begin
            seed = lcg_next(seed);
            coeff_mem[i] = 12'((seed >> 16) % Q);
        end
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);
        test_compress12();
        test_compress1_5();
        test_compress11_stall();
        test_compare_match();
        test_compare_mismatch();
        test_zeroize();
        $display("Simulation passed");
        $finish;
    end

endmodule
